// ==== verilog/cpu_ctrl_params.svh ====
`ifndef CPU_CTRL_PARAMS_SVH
`define CPU_CTRL_PARAMS_SVH

// Instruction byte
`define CPU_OPCODE_W 8

// Machine cycle counter, driven by the sequencer outside
`define CPU_MCYCLE_W 3

// Longest instruction kept here is CALL, cycles 0 to 5
`define CPU_MAX_MCYCLE 5

// Register file select, pair in bits 2:1, low byte in bit 0
`define CPU_RSEL_W 3

`endif

// ==== verilog/cpu_ctrl_pkg.sv ====
`default_nettype none

package cpu_ctrl_pkg;

    // Instruction groups the control unit tells apart
    typedef enum logic [3:0] {
        OP_MISC,    // One-cycle catch-all
        OP_STOP,
        OP_HALT,
        OP_INVALID,
        OP_LD16,
        OP_POP,
        OP_PUSH,
        OP_JP,
        OP_JR,
        OP_CALL,
        OP_RET,
        OP_RET_CC
    } op_class_e;

    typedef enum logic [1:0] {
        BUS_IDLE  = 2'd0,
        BUS_FETCH = 2'd1,
        BUS_WRITE = 2'd2,
        BUS_READ  = 2'd3
    } bus_op_e;

    typedef enum logic [1:0] {
        AB_PC   = 2'd0,
        AB_TEMP = 2'd1,
        AB_HL   = 2'd2,
        AB_SP   = 2'd3
    } ab_src_e;

    typedef enum logic [1:0] {
        CT_NONE = 2'd0,
        CT_INC  = 2'd1,
        CT_DEC  = 2'd2,
        CT_LOAD = 2'd3
    } ct_op_e;

    typedef enum logic [1:0] {
        PC_SEQ    = 2'd0,
        PC_VECTOR = 2'd1,
        PC_TEMP   = 2'd2
    } pc_src_e;

    typedef enum logic [1:0] {
        DB_REG   = 2'd0,
        DB_FLAGS = 2'd1
    } db_src_e;

    typedef enum logic [1:0] {
        SRC_ACC   = 2'd0,
        SRC_STACK = 2'd3  // Popped byte from the data bus
    } alu_src_a_e;

    typedef enum logic [1:0] {
        DST_ACC = 2'd0,
        DST_PC  = 2'd1
    } alu_dst_e;

endpackage

`default_nettype wire

// ==== verilog/decode_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_ctrl_params.svh"

interface decode_if;
    import cpu_ctrl_pkg::*;

    op_class_e                 op_class;
    logic [1:0]                reg_pair;  // Opcode bits 5:4
    logic                      taken;
    logic [`CPU_MCYCLE_W-1:0]  m_cycle;

    modport dec (output op_class, output reg_pair, output taken, output m_cycle);

    modport exe (input op_class, input taken, input m_cycle);

    modport res (input op_class, input reg_pair, input m_cycle);

endinterface

`default_nettype wire

// ==== verilog/ctrl_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_ctrl_params.svh"

module ctrl_decode (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [`CPU_OPCODE_W-1:0]  opcode_early,
    input  logic [`CPU_MCYCLE_W-1:0]  m_cycle,
    input  logic                      f_z,
    input  logic                      f_c,
    decode_if.dec                     dec
);
    import cpu_ctrl_pkg::*;

    logic [`CPU_OPCODE_W-1:0] opcode;
    op_class_e                op_class;
    logic                     cond_en;   // Conditional branch form
    logic                     cond_met;

    // Opcode arrives one clock ahead of the instruction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            opcode <= '0;  // NOP
        end else begin
            opcode <= opcode_early;
        end
    end

    ////////////////////////////////
    // Classification
    always_comb begin
        op_class = OP_MISC;
        cond_en  = 1'b0;
        case (opcode) inside
            8'h10: op_class = OP_STOP;
            8'h76: op_class = OP_HALT;
            8'hD3, 8'hDB, 8'hDD, 8'hE3, 8'hE4, 8'hEB, 8'hEC, 8'hED, 8'hF4, 8'hFC, 8'hFD:
                op_class = OP_INVALID;
            8'b00??_0001: op_class = OP_LD16;
            8'b11??_0001: op_class = OP_POP;
            8'b11??_0101: op_class = OP_PUSH;
            8'hC3: op_class = OP_JP;
            8'h18: op_class = OP_JR;
            8'hCD: op_class = OP_CALL;
            8'hC9: op_class = OP_RET;
            8'hC2, 8'hCA, 8'hD2, 8'hDA: begin
                op_class = OP_JP;
                cond_en  = 1'b1;
            end
            8'h20, 8'h28, 8'h30, 8'h38: begin
                op_class = OP_JR;
                cond_en  = 1'b1;
            end
            8'hC4, 8'hCC, 8'hD4, 8'hDC: begin
                op_class = OP_CALL;
                cond_en  = 1'b1;
            end
            8'hC0, 8'hC8, 8'hD0, 8'hD8: begin
                op_class = OP_RET_CC;
                cond_en  = 1'b1;
            end
            default: op_class = OP_MISC;
        endcase
    end

    // Condition code sits in bits 4:3 for every conditional form
    always_comb begin
        case (opcode[4:3])
            2'b00:   cond_met = !f_z;  // NZ
            2'b01:   cond_met = f_z;   // Z
            2'b10:   cond_met = !f_c;  // NC
            default: cond_met = f_c;   // C
        endcase
    end

    assign dec.op_class = op_class;
    assign dec.reg_pair = opcode[5:4];
    assign dec.taken    = cond_en ? cond_met : 1'b1;
    assign dec.m_cycle  = m_cycle;

    // Flags must be valid whenever the core is clocked
    a_taken_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(dec.taken))
        else $error("branch condition unknown, opcode %h", opcode);

endmodule

`default_nettype wire

// ==== verilog/ctrl_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_ctrl_params.svh"

module ctrl_execute (
    decode_if.exe                  exe,
    output cpu_ctrl_pkg::pc_src_e  pc_src,
    output logic                   pc_we,
    output logic                   pc_jr,
    output cpu_ctrl_pkg::bus_op_e  bus_op,
    output cpu_ctrl_pkg::ab_src_e  ab_src,
    output cpu_ctrl_pkg::ct_op_e   ct_op,
    output logic                   next,
    output logic                   stop,
    output logic                   halt
);
    import cpu_ctrl_pkg::*;

    logic multi_cycle;

    assign multi_cycle = !(exe.op_class inside {OP_MISC, OP_STOP, OP_HALT, OP_INVALID});

    always_comb begin
        // End of instruction: fetch next opcode from PC
        pc_src = PC_SEQ;
        pc_we  = 1'b0;
        pc_jr  = 1'b0;
        bus_op = BUS_FETCH;
        ab_src = AB_PC;
        ct_op  = CT_INC;
        next   = 1'b0;
        stop   = 1'b0;
        halt   = 1'b0;

        if (exe.m_cycle > `CPU_MCYCLE_W'(`CPU_MAX_MCYCLE)) begin
            stop = 1'b1;  // Sequencer ran away
            halt = 1'b1;
            next = 1'b1;
        end else if (exe.m_cycle == 3'd0) begin
            stop = (exe.op_class == OP_STOP) || (exe.op_class == OP_INVALID);
            halt = (exe.op_class == OP_HALT) || (exe.op_class == OP_INVALID);
            next = multi_cycle;
        end else begin
            case (exe.op_class)
                OP_LD16, OP_POP: begin
                    next = (exe.m_cycle == 3'd1);
                end
                OP_PUSH: begin
                    if (exe.m_cycle == 3'd1) begin
                        bus_op = BUS_WRITE;
                        next   = 1'b1;
                    end else if (exe.m_cycle == 3'd2) begin
                        bus_op = BUS_WRITE;
                        ct_op  = CT_NONE;
                        next   = 1'b1;
                    end
                end
                OP_JP: begin
                    if (exe.m_cycle == 3'd1) begin
                        next = 1'b1;
                    end else if ((exe.m_cycle == 3'd2) && exe.taken) begin
                        pc_src = PC_TEMP;  // Jump target in temp
                        pc_we  = 1'b1;
                        bus_op = BUS_IDLE;
                        ct_op  = CT_NONE;
                        next   = 1'b1;
                    end
                end
                OP_JR: begin
                    if ((exe.m_cycle == 3'd1) && exe.taken) begin
                        pc_jr = 1'b1;
                        next  = 1'b1;
                    end
                end
                OP_CALL: begin
                    if (exe.m_cycle == 3'd1) begin
                        next = 1'b1;
                    end else if ((exe.m_cycle == 3'd2) && exe.taken) begin
                        bus_op = BUS_IDLE;
                        ct_op  = CT_DEC;  // Pre-decrement SP
                        next   = 1'b1;
                    end else if (exe.m_cycle == 3'd3) begin
                        bus_op = BUS_WRITE;  // Return address high byte
                        ab_src = AB_SP;
                        ct_op  = CT_DEC;
                        next   = 1'b1;
                    end else if (exe.m_cycle == 3'd4) begin
                        pc_src = PC_TEMP;
                        pc_we  = 1'b1;
                        bus_op = BUS_WRITE;
                        ab_src = AB_SP;
                        ct_op  = CT_NONE;
                        next   = 1'b1;
                    end
                end
                OP_RET: begin
                    if (exe.m_cycle == 3'd1) begin
                        next = 1'b1;
                    end else if (exe.m_cycle == 3'd2) begin
                        bus_op = BUS_IDLE;
                        ct_op  = CT_NONE;
                        next   = 1'b1;
                    end
                end
                OP_RET_CC: begin
                    if ((exe.m_cycle == 3'd1) && exe.taken) begin
                        bus_op = BUS_READ;
                        ab_src = AB_SP;
                        ct_op  = CT_LOAD;
                        next   = 1'b1;
                    end else if (exe.m_cycle == 3'd2) begin
                        next = 1'b1;
                    end else if (exe.m_cycle == 3'd3) begin
                        bus_op = BUS_IDLE;
                        ct_op  = CT_NONE;
                        next   = 1'b1;
                    end
                end
                default: begin
                    next = 1'b0;
                end
            endcase
        end
    end

    ////////////////////////////////
    // PC update sanity
    a_pc_we_src: assert final (!pc_we || (pc_src != PC_SEQ))
        else $error("PC write with sequential source, class %0d", exe.op_class);

    a_jr_we_excl: assert final (!(pc_jr && pc_we))
        else $error("relative and absolute PC update together, class %0d", exe.op_class);

endmodule

`default_nettype wire

// ==== verilog/ctrl_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_ctrl_params.svh"

module ctrl_result (
    decode_if.res                     res,
    output logic [`CPU_RSEL_W-1:0]    rf_wr_sel,
    output logic [`CPU_RSEL_W-1:0]    rf_rd_sel,
    output cpu_ctrl_pkg::db_src_e     db_src,
    output cpu_ctrl_pkg::alu_src_a_e  alu_src_a,
    output cpu_ctrl_pkg::alu_dst_e    alu_dst,
    output logic                      pc_b_sel,
    output logic                      flags_we
);
    import cpu_ctrl_pkg::*;

    logic is_af;  // Pair 3 means AF for PUSH and POP

    assign is_af = (res.reg_pair == 2'b11);

    always_comb begin
        rf_wr_sel = '0;
        rf_rd_sel = '0;
        db_src    = DB_REG;
        alu_src_a = SRC_ACC;
        alu_dst   = DST_ACC;
        pc_b_sel  = res.m_cycle[0];  // Alternate PC byte per cycle
        flags_we  = 1'b0;

        case (res.op_class)
            OP_LD16: begin
                if (res.m_cycle == 3'd2) begin
                    rf_wr_sel = {res.reg_pair, 1'b0};
                end
            end
            OP_POP: begin
                if (res.m_cycle == 3'd2) begin
                    if (is_af) begin
                        flags_we = 1'b1;
                    end else begin
                        rf_wr_sel = {res.reg_pair, 1'b0};
                    end
                end
            end
            OP_PUSH: begin
                if (res.m_cycle == 3'd2) begin
                    if (is_af) begin
                        db_src = DB_FLAGS;
                    end else begin
                        rf_rd_sel = {res.reg_pair, 1'b1};  // Low byte of the pair
                    end
                end
            end
            OP_RET, OP_RET_CC: begin
                // RET_CC runs one cycle behind RET
                if (((res.op_class == OP_RET) && (res.m_cycle == 3'd1)) ||
                    ((res.op_class == OP_RET_CC) && (res.m_cycle == 3'd2))) begin
                    alu_src_a = SRC_STACK;
                    alu_dst   = DST_PC;
                    pc_b_sel  = 1'b0;
                end else if (((res.op_class == OP_RET) && (res.m_cycle == 3'd2)) ||
                             ((res.op_class == OP_RET_CC) && (res.m_cycle == 3'd3))) begin
                    alu_src_a = SRC_STACK;
                    alu_dst   = DST_PC;
                    pc_b_sel  = 1'b1;
                end
            end
            default: begin
                flags_we = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/cpu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_ctrl_params.svh"

module cpu_ctrl (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [`CPU_OPCODE_W-1:0]  opcode_early,
    input  logic [`CPU_MCYCLE_W-1:0]  m_cycle,
    input  logic                      f_z,
    input  logic                      f_c,
    output cpu_ctrl_pkg::pc_src_e     pc_src,
    output logic                      pc_we,
    output logic                      pc_jr,
    output cpu_ctrl_pkg::bus_op_e     bus_op,
    output cpu_ctrl_pkg::ab_src_e     ab_src,
    output cpu_ctrl_pkg::ct_op_e      ct_op,
    output logic                      next,
    output logic                      stop,
    output logic                      halt,
    output logic [`CPU_RSEL_W-1:0]    rf_wr_sel,
    output logic [`CPU_RSEL_W-1:0]    rf_rd_sel,
    output cpu_ctrl_pkg::db_src_e     db_src,
    output cpu_ctrl_pkg::alu_src_a_e  alu_src_a,
    output cpu_ctrl_pkg::alu_dst_e    alu_dst,
    output logic                      pc_b_sel,
    output logic                      flags_we
);

    decode_if dec_if ();

    ctrl_decode u_decode (
        .clk          (clk),
        .arst_n       (arst_n),
        .opcode_early (opcode_early),
        .m_cycle      (m_cycle),
        .f_z          (f_z),
        .f_c          (f_c),
        .dec          (dec_if.dec)
    );

    ////////////////////////////////
    // PC, bus and sequencing
    ctrl_execute u_execute (
        .exe    (dec_if.exe),
        .pc_src (pc_src),
        .pc_we  (pc_we),
        .pc_jr  (pc_jr),
        .bus_op (bus_op),
        .ab_src (ab_src),
        .ct_op  (ct_op),
        .next   (next),
        .stop   (stop),
        .halt   (halt)
    );

    // Register file and stack steering
    ctrl_result u_result (
        .res       (dec_if.res),
        .rf_wr_sel (rf_wr_sel),
        .rf_rd_sel (rf_rd_sel),
        .db_src    (db_src),
        .alu_src_a (alu_src_a),
        .alu_dst   (alu_dst),
        .pc_b_sel  (pc_b_sel),
        .flags_we  (flags_we)
    );

endmodule

`default_nettype wire

// ==== verification/tb_cpu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_ctrl_params.svh"

module tb_cpu_ctrl;
    import cpu_ctrl_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int FIELDS       = 20;  // Tokens per vector line
    localparam int MAX_VEC      = 64;
    localparam int VEC_CYCLES   = 8;   // Watchdog budget per vector

    logic                      clk;
    logic                      arst_n;
    logic [`CPU_OPCODE_W-1:0]  opcode_early;
    logic [`CPU_MCYCLE_W-1:0]  m_cycle;
    logic                      f_z;
    logic                      f_c;
    pc_src_e                   pc_src;
    logic                      pc_we;
    logic                      pc_jr;
    bus_op_e                   bus_op;
    ab_src_e                   ab_src;
    ct_op_e                    ct_op;
    logic                      next;
    logic                      stop;
    logic                      halt;
    logic [`CPU_RSEL_W-1:0]    rf_wr_sel;
    logic [`CPU_RSEL_W-1:0]    rf_rd_sel;
    db_src_e                   db_src;
    alu_src_a_e                alu_src_a;
    alu_dst_e                  alu_dst;
    logic                      pc_b_sel;
    logic                      flags_we;

    logic [7:0] vec_mem [FIELDS*MAX_VEC];
    logic [7:0] exp_f [16];  // Expected outputs, file column order
    int         n_vec;
    int         vec_err;
    int         n_pass;
    int         n_fail;
    bit         vectors_ready;

    cpu_ctrl u_cpu_ctrl (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // Compare tasks, one per result type
    task automatic pc_src_check(input string name, input pc_src_e got, input pc_src_e exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            vec_err++;
        end
    endtask

    task automatic bus_op_check(input string name, input bus_op_e got, input bus_op_e exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            vec_err++;
        end
    endtask

    task automatic ab_src_check(input string name, input ab_src_e got, input ab_src_e exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            vec_err++;
        end
    endtask

    task automatic ct_op_check(input string name, input ct_op_e got, input ct_op_e exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            vec_err++;
        end
    endtask

    task automatic db_src_check(input string name, input db_src_e got, input db_src_e exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            vec_err++;
        end
    endtask

    task automatic alu_src_check(input string name, input alu_src_a_e got,
                                 input alu_src_a_e exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            vec_err++;
        end
    endtask

    task automatic alu_dst_check(input string name, input alu_dst_e got, input alu_dst_e exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            vec_err++;
        end
    endtask

    // Single bits are zero extended to select width
    task automatic sel_check(input string name, input logic [2:0] got, input logic [2:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            vec_err++;
        end
    endtask

    task automatic compare_all();
        pc_src_check("pc_src", pc_src, pc_src_e'(exp_f[0][1:0]));
        sel_check("pc_we", {2'b00, pc_we}, exp_f[1][2:0]);
        sel_check("pc_jr", {2'b00, pc_jr}, exp_f[2][2:0]);
        bus_op_check("bus_op", bus_op, bus_op_e'(exp_f[3][1:0]));
        ab_src_check("ab_src", ab_src, ab_src_e'(exp_f[4][1:0]));
        ct_op_check("ct_op", ct_op, ct_op_e'(exp_f[5][1:0]));
        sel_check("next", {2'b00, next}, exp_f[6][2:0]);
        sel_check("stop", {2'b00, stop}, exp_f[7][2:0]);
        sel_check("halt", {2'b00, halt}, exp_f[8][2:0]);
        sel_check("rf_wr_sel", rf_wr_sel, exp_f[9][2:0]);
        sel_check("rf_rd_sel", rf_rd_sel, exp_f[10][2:0]);
        db_src_check("db_src", db_src, db_src_e'(exp_f[11][1:0]));
        alu_src_check("alu_src_a", alu_src_a, alu_src_a_e'(exp_f[12][1:0]));
        alu_dst_check("alu_dst", alu_dst, alu_dst_e'(exp_f[13][1:0]));
        sel_check("pc_b_sel", {2'b00, pc_b_sel}, exp_f[14][2:0]);
        sel_check("flags_we", {2'b00, flags_we}, exp_f[15][2:0]);
    endtask

    task automatic finish_test(input int num, input string what);
        if (vec_err == 0) begin
            n_pass++;
            $display("Test %0d (%s): pass", num, what);
        end else begin
            n_fail++;
            $display("Test %0d (%s): failed with %0d errors", num, what, vec_err);
        end
        vec_err = 0;
    endtask

    // Opcode goes in one edge ahead, then cycle and flags
    task automatic run_vector(input int idx);
        int base;
        int k;
        base = idx * FIELDS;
        @(negedge clk);
        opcode_early = vec_mem[base];
        @(posedge clk);
        @(negedge clk);
        m_cycle = vec_mem[base+1][2:0];
        f_z     = vec_mem[base+2][0];
        f_c     = vec_mem[base+3][0];
        for (k = 0; k < 16; k++) begin
            exp_f[k] = vec_mem[base+4+k];
        end
        #1.5;  // Just ahead of the next rising edge
        compare_all();
        finish_test(idx + 1, $sformatf("op %h cycle %0d", vec_mem[base], m_cycle));
    endtask

    initial begin
        arst_n        = 1'b0;
        opcode_early  = 8'h76;  // HALT waiting while reset is held
        m_cycle       = '0;
        f_z           = 1'b0;
        f_c           = 1'b0;
        n_vec         = 0;
        vec_err       = 0;
        n_pass        = 0;
        n_fail        = 0;
        vectors_ready = 1'b0;

        $readmemh("verification/cpu_ctrl_tests.txt", vec_mem);
        while ((n_vec < MAX_VEC) && (vec_mem[n_vec*FIELDS+1] != 8'hFF)) begin
            n_vec++;
        end
        vectors_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // Opcode register still holds its reset NOP here
        #1.5;
        exp_f = '{8'h0, 8'h0, 8'h0, 8'h1, 8'h0, 8'h1, 8'h0, 8'h0,
                  8'h0, 8'h0, 8'h0, 8'h0, 8'h0, 8'h0, 8'h0, 8'h0};
        compare_all();
        finish_test(0, "after reset");

        if (n_vec == 0) begin
            $display("No test vectors were found in the vector file");
            n_fail++;
        end
        for (int i = 0; i < n_vec; i++) begin
            run_vector(i);
        end

        $display("Summary: %0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        time limit;
        wait (vectors_ready);
        limit = time'((n_vec * VEC_CYCLES + RESET_CYCLES + 2 * VEC_CYCLES) * CLK_PERIOD);
        #(limit);
        $display("Timeout: the tests did not finish within %0t", limit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/cpu_ctrl_tests.txt ====
// opcode m_cycle f_z f_c, then pc_src pc_we pc_jr bus_op ab_src ct_op next stop halt
// rf_wr_sel rf_rd_sel db_src alu_src_a alu_dst pc_b_sel flags_we; m_cycle FF ends the list
00 0 0 0  0 0 0 1 0 1 0 0 0  0 0 0 0 0 0 0  // NOP
10 0 0 0  0 0 0 1 0 1 0 1 0  0 0 0 0 0 0 0  // STOP
76 0 0 0  0 0 0 1 0 1 0 0 1  0 0 0 0 0 0 0  // HALT
D3 0 0 0  0 0 0 1 0 1 0 1 1  0 0 0 0 0 0 0  // Reserved
00 6 0 0  0 0 0 1 0 1 1 1 1  0 0 0 0 0 0 0  // Illegal cycles
00 7 0 0  0 0 0 1 0 1 1 1 1  0 0 0 0 0 1 0
7F 3 0 0  0 0 0 1 0 1 0 0 0  0 0 0 0 0 1 0
C3 0 0 0  0 0 0 1 0 1 1 0 0  0 0 0 0 0 0 0  // JP
C3 2 0 0  2 1 0 0 0 0 1 0 0  0 0 0 0 0 0 0
C2 2 1 0  0 0 0 1 0 1 0 0 0  0 0 0 0 0 0 0
C2 2 0 0  2 1 0 0 0 0 1 0 0  0 0 0 0 0 0 0
C3 3 0 0  0 0 0 1 0 1 0 0 0  0 0 0 0 0 1 0
20 1 0 0  0 0 1 1 0 1 1 0 0  0 0 0 0 0 1 0  // JR
20 1 1 0  0 0 0 1 0 1 0 0 0  0 0 0 0 0 1 0
38 1 0 1  0 0 1 1 0 1 1 0 0  0 0 0 0 0 1 0
CD 1 0 0  0 0 0 1 0 1 1 0 0  0 0 0 0 0 1 0  // CALL
DC 2 0 0  0 0 0 1 0 1 0 0 0  0 0 0 0 0 0 0
DC 2 0 1  0 0 0 0 0 2 1 0 0  0 0 0 0 0 0 0
CD 3 0 0  0 0 0 2 3 2 1 0 0  0 0 0 0 0 1 0
CD 4 0 0  2 1 0 2 3 0 1 0 0  0 0 0 0 0 0 0
CD 5 0 0  0 0 0 1 0 1 0 0 0  0 0 0 0 0 1 0
C8 1 1 0  0 0 0 3 3 3 1 0 0  0 0 0 0 0 1 0  // RET cc
C8 1 0 0  0 0 0 1 0 1 0 0 0  0 0 0 0 0 1 0
C0 2 0 0  0 0 0 1 0 1 1 0 0  0 0 0 3 1 0 0
C0 3 0 0  0 0 0 0 0 0 1 0 0  0 0 0 3 1 1 0
C0 4 0 0  0 0 0 1 0 1 0 0 0  0 0 0 0 0 0 0
C9 1 0 0  0 0 0 1 0 1 1 0 0  0 0 0 3 1 0 0  // RET
C9 2 0 0  0 0 0 0 0 0 1 0 0  0 0 0 3 1 1 0
C9 3 0 0  0 0 0 1 0 1 0 0 0  0 0 0 0 0 1 0
C5 1 0 0  0 0 0 2 0 1 1 0 0  0 0 0 0 0 1 0  // PUSH
C5 2 0 0  0 0 0 2 0 0 1 0 0  0 1 0 0 0 0 0
F5 2 0 0  0 0 0 2 0 0 1 0 0  0 0 1 0 0 0 0
C5 3 0 0  0 0 0 1 0 1 0 0 0  0 0 0 0 0 1 0
C1 2 0 0  0 0 0 1 0 1 0 0 0  0 0 0 0 0 0 0  // POP
D1 2 0 0  0 0 0 1 0 1 0 0 0  2 0 0 0 0 0 0
F1 2 0 0  0 0 0 1 0 1 0 0 0  0 0 0 0 0 0 1
21 1 0 0  0 0 0 1 0 1 1 0 0  0 0 0 0 0 1 0  // LD16
21 2 0 0  0 0 0 1 0 1 0 0 0  4 0 0 0 0 0 0
31 2 0 0  0 0 0 1 0 1 0 0 0  6 0 0 0 0 0 0
FF FF FF FF  FF FF FF FF FF FF FF FF FF  FF FF FF FF FF FF FF

// ==== verilog.f ====
+incdir+verilog
verilog/cpu_ctrl_pkg.sv
verilog/decode_if.sv
verilog/ctrl_decode.sv
verilog/ctrl_execute.sv
verilog/ctrl_result.sv
verilog/cpu_ctrl.sv
verification/tb_cpu_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cpu_ctrl testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_cpu_ctrl -o sim_cpu_ctrl \
    && ./obj_dir/sim_cpu_ctrl | tee /dev/stderr | grep -qx "PASS: all tests" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
